// File: files.f
+incdir+hdl
hdl/board_pkg.sv
hdl/slow_clk_gen.sv
hdl/hex_digit_scanner.sv
hdl/lab_top.sv
hdl/tm1638_board_controller.sv
hdl/board_specific_top.sv
verification/tm1638_model.sv
verification/tb_board_specific_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_specific_top -f files.f -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    && grep -qx "all tests passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: verification/tb_board_specific_top.sv
`timescale 1ns/10ps

`include "config.svh"
`include "lab_specific_config.svh"

module tb_board_specific_top;

    // About 30 frames of roughly 5000 cycles each, with margin.
    localparam int timeout_cycles = 200000;

    logic            clk;
    logic            arst_n;
    logic [1:0]      sw;
    logic            sio_clk;
    logic            sio_stb;
    logic            sio_dio_out;
    logic            sio_dio_oe;
    logic            sio_dio_in;
    logic [7:0]      key_state;
    logic [7:0][7:0] digit_seg;
    logic [7:0]      led_bits;
    int              frame_count;
    int              protocol_errors;
    int              errors = 0;
    int              cycles = 0;

    board_specific_top
    #(
        .clk_mhz     (`CLK_MHZ),
        .slow_clk_hz (`SLOW_CLK_HZ)
    )
    u_dut
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .sw          (sw),
        .sio_clk     (sio_clk),
        .sio_stb     (sio_stb),
        .sio_dio_out (sio_dio_out),
        .sio_dio_oe  (sio_dio_oe),
        .sio_dio_in  (sio_dio_in)
    );

    tm1638_model u_model
    (
        .sio_clk         (sio_clk),
        .sio_stb         (sio_stb),
        .dio_out         (sio_dio_out),
        .dio_oe          (sio_dio_oe),
        .key_state       (key_state),
        .dio_in          (sio_dio_in),
        .digit_seg       (digit_seg),
        .led_bits        (led_bits),
        .frame_count     (frame_count),
        .protocol_errors (protocol_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==========================================================
    // Helpers
    // ==========================================================

    // Segment pattern of a hex digit as the chip receives it, a in bit 0.
    function automatic logic [7:0] hex_to_seg(input logic [3:0] n);
        case (n)
            4'h0:    return 8'h3F;
            4'h1:    return 8'h06;
            4'h2:    return 8'h5B;
            4'h3:    return 8'h4F;
            4'h4:    return 8'h66;
            4'h5:    return 8'h6D;
            4'h6:    return 8'h7D;
            4'h7:    return 8'h07;
            4'h8:    return 8'h7F;
            4'h9:    return 8'h6F;
            4'hA:    return 8'h77;
            4'hB:    return 8'h7C;
            4'hC:    return 8'h39;
            4'hD:    return 8'h5E;
            4'hE:    return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    // Returns just after the clock edge that follows the n-th frame end.
    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target)
            @(posedge clk);
        #2;
    endtask

    task automatic press_keys(input logic [7:0] mask);
        key_state = mask;
        wait_frames(1);
        key_state = '0;
        wait_frames(1);
    endtask

    task automatic expect_display(input logic [31:0] value, input string what);
        for (int i = 0; i < 8; i++)
        begin
            assert (digit_seg[i] == hex_to_seg(value[4*i +: 4]))
            else
            begin
                $display("FAIL %0t ns: %s, digit %0d shows %h, expected %h",
                         $time, what, i, digit_seg[i], hex_to_seg(value[4*i +: 4]));
                errors++;
            end
        end
        assert (led_bits == value[7:0])
        else
        begin
            $display("FAIL %0t ns: %s, LEDs show %h, expected %h",
                     $time, what, led_bits, value[7:0]);
            errors++;
        end
    endtask

    task automatic read_display(output logic [31:0] value, output logic ok);
        logic found;
        value = '0;
        ok    = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            found = 1'b0;
            for (int n = 0; n < 16; n++)
            begin
                if (!found && digit_seg[i] == hex_to_seg(4'(n)))
                begin
                    value[4*i +: 4] = 4'(n);
                    found           = 1'b1;
                end
            end
            ok = ok & found;
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d in checks, %0d in the serial protocol, after %0d frames.",
                 errors, protocol_errors, frame_count);
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================

    task automatic test_reset_state();
        wait_frames(2);
        expect_display(32'h0, "after reset");
    endtask

    task automatic test_key_step();
        for (int i = 0; i < 3; i++)
            press_keys(8'h01);
        expect_display(32'h3, "three key steps up");
        sw = 2'b10;
        press_keys(8'h01);
        expect_display(32'h2, "one key step down");
    endtask

    task automatic test_clear();
        press_keys(8'h80);
        expect_display(32'h0, "clear key");
    endtask

    task automatic test_run();
        logic [31:0] v;
        logic [31:0] v_later;
        logic        ok;
        sw = 2'b01;
        repeat (30000) @(posedge clk);
        #2 sw = 2'b00;
        wait_frames(2);
        read_display(v, ok);
        assert (ok)
        else
        begin
            $display("FAIL %0t ns: a digit after the run is no hex pattern", $time);
            errors++;
        end
        assert (v > 0 && v <= 4)
        else
        begin
            $display("FAIL %0t ns: count after the run is %h, expected 1 to 4", $time, v);
            errors++;
        end
        assert (led_bits == v[7:0])
        else
        begin
            $display("FAIL %0t ns: LEDs show %h after the run, expected %h",
                     $time, led_bits, v[7:0]);
            errors++;
        end
        wait_frames(2);
        read_display(v_later, ok);
        assert (v_later == v)
        else
        begin
            $display("FAIL %0t ns: stopped count moved from %h to %h", $time, v, v_later);
            errors++;
        end
    endtask

    task automatic test_key_combo();
        press_keys(8'h81);
        expect_display(32'h0, "step and clear together");
        press_keys(8'h08);
        expect_display(32'h0, "key without a function");
    endtask

    // ==========================================================
    // Sequence and watchdog
    // ==========================================================

    initial
    begin
        arst_n    = 1'b0;
        sw        = 2'b00;
        key_state = '0;
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;

        test_reset_state();
        test_key_step();
        test_clear();
        test_run();
        test_key_combo();

        report_counts();
        if (errors == 0 && protocol_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles)
        begin
            $display("Timeout: the tests did not finish within %0d clock cycles.",
                     timeout_cycles);
            report_counts();
            $display("tests failed");
            $finish;
        end
    end

endmodule

// File: verification/tm1638_model.sv
`timescale 1ns/10ps

module tm1638_model
(
    input  logic            sio_clk,
    input  logic            sio_stb,
    input  logic            dio_out,
    input  logic            dio_oe,
    input  logic [7:0]      key_state,
    output logic            dio_in,
    output logic [7:0][7:0] digit_seg,
    output logic [7:0]      led_bits,
    output int              frame_count,
    output int              protocol_errors
);

    int              transfer;
    int              byte_cnt;
    int              bit_cnt;
    int              read_bit;
    logic            in_transfer;
    logic [7:0]      shift;
    logic [7:0][7:0] seg_buf;
    logic [7:0]      led_buf;

    initial
    begin
        dio_in          = 1'b1;
        digit_seg       = '0;
        led_bits        = '0;
        frame_count     = 0;
        protocol_errors = 0;
        transfer        = 0;
        byte_cnt        = 0;
        bit_cnt         = 0;
        read_bit        = 0;
        in_transfer     = 1'b0;
        shift           = '0;
        seg_buf         = '0;
        led_buf         = '0;
    end

    // ==========================================================
    // Frame layout of the chip
    // ==========================================================

    function automatic logic [7:0] opening_command(input int t);
        case (t)
            0:       return 8'h40;
            1:       return 8'hC0;
            2:       return 8'h8F;
            default: return 8'h42;
        endcase
    endfunction

    function automatic int bytes_in_transfer(input int t);
        case (t)
            1:       return 17;
            3:       return 5;
            default: return 1;
        endcase
    endfunction

    // Read byte i holds key 2i in bit 0 and key 2i+1 in bit 4.
    function automatic logic key_bit(input int idx);
        int b;
        int k;
        b = idx % 8;
        k = 2 * (idx / 8);
        if (b == 0)
            return key_state[k];
        else if (b == 4)
            return key_state[k + 1];
        else
            return 1'b0;
    endfunction

    task automatic take_byte(input logic [7:0] b);
        int idx;
        idx = byte_cnt - 1;
        if (byte_cnt == 0)
        begin
            assert (b == opening_command(transfer))
            else
            begin
                $display("Protocol error at %0t ns: transfer %0d opened with %h instead of %h.",
                         $time, transfer, b, opening_command(transfer));
                protocol_errors++;
            end
        end
        else if (transfer == 1 && idx < 16)
        begin
            if (idx % 2 == 0)
                seg_buf[idx / 2] = b;
            else
                led_buf[idx / 2] = b[0];
        end
    endtask

    // ==========================================================
    // Serial interface
    // ==========================================================

    always @(negedge sio_stb)
    begin
        in_transfer = 1'b1;
        byte_cnt    = 0;
        bit_cnt     = 0;
        read_bit    = 0;
    end

    // Only clock edges inside an open transfer carry data.
    always @(posedge sio_clk)
    begin
        if (in_transfer && !sio_stb)
        begin
            if (transfer == 3 && byte_cnt >= 1)
            begin
                assert (!dio_oe)
                else
                begin
                    $display("Protocol error at %0t ns: data line driven during a key read.",
                             $time);
                    protocol_errors++;
                end
                read_bit = read_bit + 1;
                if (read_bit % 8 == 0)
                    byte_cnt = byte_cnt + 1;
            end
            else
            begin
                assert (dio_oe)
                else
                begin
                    $display("Protocol error at %0t ns: data line released in a write byte.",
                             $time);
                    protocol_errors++;
                end
                shift   = {dio_out, shift[7:1]};
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8)
                begin
                    bit_cnt = 0;
                    take_byte(shift);
                    byte_cnt = byte_cnt + 1;
                end
            end
        end
    end

    // Key data changes on the falling clock edge, as on the real chip.
    always @(negedge sio_clk)
    begin
        if (!sio_stb && transfer == 3 && byte_cnt >= 1)
            dio_in = key_bit(read_bit);
    end

    always @(posedge sio_stb)
    begin
        if (in_transfer)
        begin
            in_transfer = 1'b0;
            dio_in      = 1'b1;
            assert (bit_cnt == 0 && read_bit % 8 == 0)
            else
            begin
                $display("Protocol error at %0t ns: transfer %0d ended in the middle of a byte.",
                         $time, transfer);
                protocol_errors++;
            end
            assert (byte_cnt == bytes_in_transfer(transfer))
            else
            begin
                $display("Protocol error at %0t ns: transfer %0d carried %0d bytes, not %0d.",
                         $time, transfer, byte_cnt, bytes_in_transfer(transfer));
                protocol_errors++;
            end
            if (transfer == 3)
            begin
                digit_seg   = seg_buf;
                led_bits    = led_buf;
                frame_count = frame_count + 1;
                transfer    = 0;
            end
            else
            begin
                transfer = transfer + 1;
            end
        end
    end

endmodule

// File: hdl/board_specific_top.sv
`timescale 1ns/10ps

`include "config.svh"
`include "lab_specific_config.svh"

module board_specific_top
#(
    parameter int clk_mhz     = `CLK_MHZ,
    parameter int slow_clk_hz = `SLOW_CLK_HZ
)
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [1:0] sw,
    output logic       sio_clk,
    output logic       sio_stb,
    output logic       sio_dio_out,
    output logic       sio_dio_oe,
    input  logic       sio_dio_in
);

    import board_pkg::*;

    logic                 slow_clk;
    logic [tm_keys-1:0]   keys;
    logic [tm_digits-1:0] led;
    seg_bus_t             lab_seg;
    seg_bus_t             tm_seg;
    tm_serial_t           tm_serial;
    wire  [7:0]           hgfedcba;

    // ==========================================================
    // Counting clock
    // ==========================================================

    slow_clk_gen
    #(
        .fast_clk_mhz (clk_mhz),
        .slow_clk_hz  (slow_clk_hz)
    )
    u_slow_clk_gen
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .slow_clk (slow_clk)
    );

    // ==========================================================
    // Lab design
    // ==========================================================

    lab_top u_lab_top
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .slow_clk (slow_clk),
        .keys     (keys),
        .sw       (sw),
        .led      (led),
        .seg      (lab_seg)
    );

    // The lab puts segment a in bit 7, the chip wants it in bit 0.
    generate
        for (genvar i = 0; i < 8; i++)
        begin : g_seg_reverse
            assign hgfedcba[i] = lab_seg.hgfedcba[7 - i];
        end
    endgenerate

    assign tm_seg = '{hgfedcba: hgfedcba, digit: lab_seg.digit};

    // ==========================================================
    // TM1638 module
    // ==========================================================

    tm1638_board_controller
    #(
        .clk_mhz (clk_mhz)
    )
    u_tm1638
    (
        .clk    (clk),
        .arst_n (arst_n),
        .seg    (tm_seg),
        .led    (led),
        .dio_in (sio_dio_in),
        .serial (tm_serial),
        .keys   (keys)
    );

    // The data pin is split; the pad buffer sits outside this design.
    assign sio_clk     = tm_serial.sio_clk;
    assign sio_stb     = tm_serial.sio_stb;
    assign sio_dio_out = tm_serial.dio_out;
    assign sio_dio_oe  = tm_serial.dio_oe;

endmodule

// File: hdl/tm1638_board_controller.sv
`timescale 1ns/10ps

module tm1638_board_controller
#(
    parameter int clk_mhz = 25
)
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  board_pkg::seg_bus_t             seg,
    input  logic [board_pkg::tm_digits-1:0] led,
    input  logic                            dio_in,
    output board_pkg::tm_serial_t           serial,
    output logic [board_pkg::tm_keys-1:0]   keys
);

    import board_pkg::*;

    // Byte positions within one frame of four transfers.
    localparam int half_period   = (clk_mhz / 2 > 0) ? clk_mhz / 2 : 1;
    localparam int w_div         = (half_period > 1) ? $clog2(half_period) : 1;
    localparam int n_read        = tm_keys / 2;
    localparam int idx_data_last = 2 * tm_digits + 1;
    localparam int idx_disp_on   = idx_data_last + 1;
    localparam int idx_read_cmd  = idx_disp_on + 1;
    localparam int idx_last      = idx_read_cmd + n_read;
    localparam int w_idx         = $clog2(idx_last + 1);

    logic [7:0]           seg_store  [tm_digits];
    logic [7:0]           seg_shadow [tm_digits];
    logic [tm_digits-1:0] led_shadow;
    tm_state_t            state;
    logic [w_div-1:0]     div_cnt;
    logic                 tick;
    logic [3:0]           bit_cnt;
    logic [2:0]           next_bit;
    logic [w_idx-1:0]     byte_idx;
    logic [7:0]           cur_byte;
    logic [7:0]           next_byte;
    logic                 last_of_transfer;
    logic                 next_is_read;
    logic                 frame_end;
    logic [8*n_read-1:0]  key_shift;

    // Byte idx of the frame: commands, then digit and LED pairs.
    function automatic logic [7:0] frame_byte(input logic [w_idx-1:0] idx);
        logic [w_idx-1:0] d;
        d = idx - w_idx'(2);
        if (idx == 0)
            return cmd_write_auto;
        else if (idx == 1)
            return cmd_address_0;
        else if (idx <= idx_data_last)
            return d[0] ? {7'b0, led_shadow[d[$clog2(tm_digits):1]]}
                        : seg_shadow[d[$clog2(tm_digits):1]];
        else if (idx == idx_disp_on)
            return cmd_display_on;
        else if (idx == idx_read_cmd)
            return cmd_read_keys;
        else
            return 8'h00;
    endfunction

    // ==========================================================
    // Segment store and frame snapshot
    // ==========================================================

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < tm_digits; i++)
        begin
            if (seg.digit[i])
                seg_store[i] <= seg.hgfedcba;
        end
        if (tick && state == idle)
        begin
            seg_shadow <= seg_store;
            led_shadow <= led;
        end
    end

    // ==========================================================
    // Serial sequencer
    // ==========================================================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            div_cnt <= '0;
        else
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end

    assign tick             = (div_cnt == w_div'(half_period - 1));
    assign next_bit         = bit_cnt[3:1] + 3'd1;
    assign cur_byte         = frame_byte(byte_idx);
    assign next_byte        = frame_byte(byte_idx + 1'b1);
    assign next_is_read     = (byte_idx >= idx_read_cmd);
    assign last_of_transfer = (byte_idx == 0) || (byte_idx == idx_data_last) ||
                              (byte_idx == idx_disp_on) || (byte_idx == idx_last);

    // Even bit_cnt values are the low half of sio_clk, odd ones the high half.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= idle;
            bit_cnt   <= '0;
            byte_idx  <= '0;
            frame_end <= 1'b0;
            key_shift <= '0;
            serial    <= '{sio_clk: 1'b1, sio_stb: 1'b1, dio_out: 1'b1, dio_oe: 1'b0};
        end
        else
        begin
            frame_end <= 1'b0;
            if (tick)
            begin
                case (state)
                    idle, start:
                    begin
                        if (state == idle)
                        begin
                            serial.sio_stb <= 1'b0;
                            serial.dio_oe  <= 1'b1;
                            state          <= start;
                        end
                        else
                        begin
                            serial.sio_clk <= 1'b0;
                            serial.dio_out <= cur_byte[0];
                            bit_cnt        <= '0;
                            state          <= shift_byte;
                        end
                    end
                    shift_byte, read_byte:
                    begin
                        if (!bit_cnt[0])
                        begin
                            // The chip changes dio on the falling edge.
                            serial.sio_clk <= 1'b1;
                            bit_cnt        <= bit_cnt + 1'b1;
                            if (state == read_byte)
                                key_shift <= {dio_in, key_shift[8*n_read-1:1]};
                        end
                        else if (bit_cnt != 4'd15)
                        begin
                            serial.sio_clk <= 1'b0;
                            serial.dio_out <= cur_byte[next_bit];
                            bit_cnt        <= bit_cnt + 1'b1;
                        end
                        else if (last_of_transfer)
                        begin
                            serial.sio_stb <= 1'b1;
                            serial.dio_oe  <= 1'b0;
                            bit_cnt        <= '0;
                            state          <= stop_gap;
                            frame_end      <= (byte_idx == idx_last);
                            byte_idx       <= (byte_idx == idx_last) ? '0 : byte_idx + 1'b1;
                        end
                        else
                        begin
                            serial.sio_clk <= 1'b0;
                            serial.dio_out <= next_byte[0];
                            serial.dio_oe  <= !next_is_read;
                            bit_cnt        <= '0;
                            byte_idx       <= byte_idx + 1'b1;
                            state          <= next_is_read ? read_byte : shift_byte;
                        end
                    end
                    default:
                    begin
                        // Strobe stays high for eight half periods.
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd7)
                        begin
                            bit_cnt <= '0;
                            if (byte_idx == 0)
                            begin
                                state <= idle;
                            end
                            else
                            begin
                                serial.sio_stb <= 1'b0;
                                serial.dio_oe  <= 1'b1;
                                state          <= start;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // Read byte i carries key 2i in bit 0 and key 2i+1 in bit 4.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            keys <= '0;
        else if (frame_end)
        begin
            for (int i = 0; i < n_read; i++)
            begin
                keys[2*i]   <= key_shift[8*i];
                keys[2*i+1] <= key_shift[8*i+4];
            end
        end
    end

    a_clk_in_transfer: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(serial.sio_clk) |-> !serial.sio_stb && !$past(serial.sio_stb));

    a_read_released: assert property (@(posedge clk) disable iff (!arst_n)
        (state == read_byte) |-> !serial.dio_oe);

endmodule

// File: hdl/lab_top.sv
`timescale 1ns/10ps

module lab_top
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            slow_clk,
    input  logic [board_pkg::tm_keys-1:0]   keys,
    input  logic [1:0]                      sw,
    output logic [board_pkg::tm_digits-1:0] led,
    output board_pkg::seg_bus_t             seg
);

    import board_pkg::*;

    logic [31:0]        count;
    logic               slow_clk_q;
    logic [tm_keys-1:0] keys_q;
    logic               slow_rise;
    logic               key_step;
    logic               step;
    logic               clear;

    // ==========================================================
    // Edge detection
    // ==========================================================

    // The slow clock is a plain register output in the clk domain,
    // so it is sampled like any other signal.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            slow_clk_q <= 1'b0;
            keys_q     <= '0;
        end
        else
        begin
            slow_clk_q <= slow_clk;
            keys_q     <= keys;
        end
    end

    assign slow_rise = slow_clk & ~slow_clk_q;
    assign key_step  = keys[0] & ~keys_q[0];
    assign step      = (sw[0] & slow_rise) | key_step;
    assign clear     = keys[tm_keys-1];

    // ==========================================================
    // Counter
    // ==========================================================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            count <= '0;
        else if (clear)
            count <= '0;
        else if (step)
            count <= sw[1] ? count - 1'b1 : count + 1'b1;
    end

    assign led = count[tm_digits-1:0];

    hex_digit_scanner u_scanner
    (
        .clk    (clk),
        .arst_n (arst_n),
        .value  (count),
        .seg    (seg)
    );

endmodule

// File: hdl/hex_digit_scanner.sv
`timescale 1ns/10ps

module hex_digit_scanner
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic [31:0]         value,
    output board_pkg::seg_bus_t seg
);

    import board_pkg::*;

    logic [tm_digits-1:0] digit;
    logic [3:0]           nibble;
    logic [7:0]           abcdefgh;

    // The select walks from digit 0 upward, one digit per clock.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            digit <= tm_digits'(1);
        else
            digit <= {digit[tm_digits-2:0], digit[tm_digits-1]};
    end

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < tm_digits; i++)
        begin
            if (digit[i])
                nibble = nibble | value[4*i +: 4];
        end
    end

    // Segment a sits in bit 7, the point h in bit 0 and stays dark.
    always_comb
    begin
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'hA: abcdefgh = 8'b1110_1110;
            4'hB: abcdefgh = 8'b0011_1110;
            4'hC: abcdefgh = 8'b1001_1100;
            4'hD: abcdefgh = 8'b0111_1010;
            4'hE: abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;
        endcase
    end

    // On the lab side the segment field still carries abcdefgh order.
    // The board top flips it before it reaches the controller.
    assign seg = '{hgfedcba: abcdefgh, digit: digit};

    a_digit_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(digit));

endmodule

// File: hdl/slow_clk_gen.sv
`timescale 1ns/10ps

module slow_clk_gen
#(
    parameter int fast_clk_mhz = 25,
    parameter int slow_clk_hz  = 2500
)
(
    input  logic clk,
    input  logic arst_n,
    output logic slow_clk
);

    // Number of fast clock cycles between two slow_clk edges.
    localparam int half_period = fast_clk_mhz * 1000000 / (2 * slow_clk_hz);
    localparam int w_cnt       = (half_period > 1) ? $clog2(half_period) : 1;

    logic [w_cnt-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end
        else if (cnt == w_cnt'(half_period - 1))
        begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    a_half_period_valid: assert property (@(posedge clk) disable iff (!arst_n)
        half_period >= 1);

endmodule

// File: hdl/board_pkg.sv
package board_pkg;

`include "config.svh"

    // ==========================================================
    // TM1638 geometry
    // ==========================================================

    localparam int tm_digits = `TM1638_DIGITS;
    localparam int tm_keys   = 8;

    // ==========================================================
    // Controller types
    // ==========================================================

    typedef enum logic [2:0]
    {
        idle,
        start,
        shift_byte,
        read_byte,
        stop_gap
    } tm_state_t;

    // Command opcodes of the chip.
    typedef enum logic [7:0]
    {
        cmd_write_auto = 8'h40,
        cmd_read_keys  = 8'h42,
        cmd_address_0  = 8'hC0,
        cmd_display_on = 8'h8F
    } tm_cmd_t;

    // Segment pattern of the scanned digit and its one-hot select.
    typedef struct packed
    {
        logic [7:0] hgfedcba;
        logic [7:0] digit;
    } seg_bus_t;

    typedef struct packed
    {
        logic sio_clk;
        logic sio_stb;
        logic dio_out;
        logic dio_oe;
    } tm_serial_t;

endpackage

// File: hdl/config.svh
`ifndef CONFIG_SVH
`define CONFIG_SVH

// Board clock in MHz and the digit count of the TM1638 module.
`define CLK_MHZ       25
`define TM1638_DIGITS 8

`endif

// File: hdl/lab_specific_config.svh
`ifndef LAB_SPECIFIC_CONFIG_SVH
`define LAB_SPECIFIC_CONFIG_SVH

// Rate of the counting clock used by the lab.
`define SLOW_CLK_HZ 2500

`endif
